// File: design/dma_ctrl_fsm.sv
/* Chain controller
   Walks the descriptor chain, loads the counter and raises the interrupt
*/
module dma_ctrl_fsm (
   input  logic                     wb_clk_i,
   input  logic                     wb_rst_i,
   input  dma_reg_pkg::reg_ctl_t    reg_ctl_i,
   output dma_desc_pkg::ctrl_stat_t ctrl_stat_o,
   output dma_desc_pkg::slot_t      desc_slot_o,
   input  dma_desc_pkg::desc_t      desc_i,
   output logic                     load_o,
   output dma_desc_pkg::desc_t      load_desc_o,
   input  logic                     done_i,
   output logic                     int_o
);
   import dma_desc_pkg::*;

   ctrl_state_e state_q;
   slot_t       cur_slot_q;
   slot_t       next_slot_q;
   logic        last_q;
   logic        first_q;
   logic        int_q;

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         state_q     <= IDLE;
         cur_slot_q  <= '0;
         next_slot_q <= '0;
         last_q      <= 1'b0;
         first_q     <= 1'b0;
      end else begin
         case (state_q)
            IDLE: begin
               if (reg_ctl_i.enable && reg_ctl_i.ndar_dirty) begin
                  state_q    <= LOAD;
                  cur_slot_q <= reg_ctl_i.ndar_slot;
                  first_q    <= 1'b1;
               end
            end
            // Link and last flag are kept so later table writes can't bend the chain
            LOAD: begin
               state_q     <= RUN;
               next_slot_q <= desc_i.next;
               last_q      <= desc_i.last;
               first_q     <= 1'b0;
            end
            RUN: begin
               if (done_i) begin
                  if (last_q) begin
                     state_q <= IDLE;
                  end else begin
                     state_q    <= LOAD;
                     cur_slot_q <= next_slot_q;
                  end
               end
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   // End of chain interrupt
   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         int_q <= 1'b0;
      end else if (state_q == RUN && done_i && last_q) begin
         int_q <= 1'b1;
      end else if (reg_ctl_i.int_clear) begin
         int_q <= 1'b0;
      end
   end

   assign desc_slot_o = cur_slot_q;
   assign load_o      = (state_q == LOAD);
   assign load_desc_o = desc_i;
   assign int_o       = int_q;

   assign ctrl_stat_o.busy       = (state_q != IDLE);
   assign ctrl_stat_o.int_pend   = int_q;
   assign ctrl_stat_o.cur_slot   = cur_slot_q;
   assign ctrl_stat_o.ndar_clear = load_o && first_q;

   // A load is always followed by running the descriptor
   a_load_in_load: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      load_o |-> (state_q == LOAD) ##1 (state_q == RUN));

   a_done_in_run: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      done_i |-> (state_q == RUN));

endmodule

// File: design/dma_desc_pkg.sv
/* DMA descriptor definitions
   Descriptor layout, slot index and the chain controller's state and status
*/
package dma_desc_pkg;

   // Slot index into the descriptor table
   typedef logic [1:0] slot_t;

   // One scatter-gather descriptor, length in words and never zero
   typedef struct packed {
      logic        last;
      slot_t       next;
      logic [15:0] length;
      logic [29:0] addr;
   } desc_t;

   typedef enum logic [1:0] {
      IDLE,
      LOAD,
      RUN
   } ctrl_state_e;

   // Chain controller status seen by the register block
   typedef struct packed {
      logic  busy;
      logic  int_pend;
      slot_t cur_slot;
      logic  ndar_clear;
   } ctrl_stat_t;

endpackage

// File: design/dma_desc_table.sv
/* Descriptor table
   Field-wise bus writes, one read port for the bus and one for the FSM
*/
module dma_desc_table #(
   parameter int DESC_SLOTS = 4
) (
   input  logic                wb_clk_i,
   input  logic                we_i,
   input  dma_desc_pkg::slot_t wslot_i,
   input  logic                wfield_i,
   input  logic [31:0]         wdata_i,
   input  dma_desc_pkg::slot_t bus_slot_i,
   input  dma_desc_pkg::slot_t fsm_slot_i,
   output dma_desc_pkg::desc_t bus_desc_o,
   output dma_desc_pkg::desc_t fsm_desc_o
);
   import dma_desc_pkg::*;

   desc_t mem [DESC_SLOTS];

   // ************************************************************************
   // Write port
   // ************************************************************************

   // Field 0 holds last, next and length, field 1 the word address
   always_ff @(posedge wb_clk_i) begin
      if (we_i) begin
         if (!wfield_i) begin
            mem[wslot_i].last   <= wdata_i[31];
            mem[wslot_i].next   <= wdata_i[17:16];
            mem[wslot_i].length <= wdata_i[15:0];
         end else begin
            mem[wslot_i].addr <= wdata_i[31:2];
         end
      end
   end

   // ************************************************************************
   // Read ports
   // ************************************************************************

   assign bus_desc_o = mem[bus_slot_i];
   assign fsm_desc_o = mem[fsm_slot_i];

endmodule

// File: design/dma_reg_pkg.sv
/* DMA register map
   Register indices, register word layouts and the controls sent to the FSM
*/
package dma_reg_pkg;

   // Register index from address bits 6:2
   typedef logic [4:0] reg_idx_t;

   localparam reg_idx_t REG_CCR   = 5'd0;
   localparam reg_idx_t REG_CSR   = 5'd1;
   localparam reg_idx_t REG_DAR   = 5'd2;
   localparam reg_idx_t REG_NDAR  = 5'd3;
   localparam reg_idx_t REG_COUNT = 5'd4;

   // Channel control word, bit 0 is kept free where append used to be
   typedef struct packed {
      logic [31:3] rsvd_hi;
      logic        int_clear;
      logic        enable;
      logic        rsvd_append;
   } ccr_t;

   // Slot sits where the table's own bus address keeps it
   typedef struct packed {
      logic [31:6]         rsvd_hi;
      dma_desc_pkg::slot_t slot;
      logic [3:0]          rsvd_lo;
   } ndar_t;

   typedef union packed {
      ccr_t        ccr;
      ndar_t       ndar;
      logic [31:0] raw;
   } reg_wdata_u;

   typedef struct packed {
      logic                enable;
      logic                ndar_dirty;
      dma_desc_pkg::slot_t ndar_slot;
      logic                int_clear;
   } reg_ctl_t;

endpackage

// File: design/dma_regs.sv
/* Wishbone slave register block of the DMA engine
   Decodes control registers and the descriptor table, answers with ack or err
*/
module dma_regs (
   input  logic                     wb_clk_i,
   input  logic                     wb_rst_i,
   input  logic                     wbs_cyc_i,
   input  logic                     wbs_stb_i,
   input  logic                     wbs_we_i,
   input  logic [3:0]               wbs_sel_i,
   input  logic [31:0]              wbs_adr_i,
   input  logic [31:0]              wbs_dat_i,
   output logic [31:0]              wbs_dat_o,
   output logic                     wbs_ack_o,
   output logic                     wbs_err_o,
   output dma_reg_pkg::reg_ctl_t    reg_ctl_o,
   output logic                     tbl_we_o,
   output dma_desc_pkg::slot_t      tbl_slot_o,
   output logic                     tbl_field_o,
   output logic [31:0]              tbl_wdata_o,
   input  dma_desc_pkg::desc_t      tbl_rdata_i,
   input  dma_desc_pkg::ctrl_stat_t ctrl_stat_i,
   input  logic [15:0]              count_i
);
   import dma_reg_pkg::*;
   import dma_desc_pkg::*;

   logic        req;
   logic        reg_sel;
   reg_idx_t    idx;
   reg_wdata_u  wdata;
   logic        wr;
   logic        ccr_wr;
   logic        ndar_wr;
   logic        ndar_bad;
   logic        enable_q;
   logic        ndar_dirty_q;
   logic        int_clear_q;
   slot_t       ndar_slot_q;
   ccr_t        ccr_rd;
   ndar_t       ndar_rd;
   ndar_t       dar_rd;
   logic [31:0] rd_mux;

   // ************************************************************************
   // Decode
   // ************************************************************************

   // A request is not answered twice while stb stays up
   assign req     = wbs_cyc_i && wbs_stb_i && !wbs_ack_o && !wbs_err_o;
   assign reg_sel = wbs_adr_i[10];
   assign idx     = wbs_adr_i[6:2];
   assign wdata.raw = wbs_dat_i;

   // Only full-word writes land
   assign wr      = req && wbs_we_i && (wbs_sel_i == 4'hf);
   assign ccr_wr  = wr && reg_sel && (idx == REG_CCR);
   assign ndar_wr = wr && reg_sel && (idx == REG_NDAR) && !enable_q;

   // NDAR is locked while the channel is enabled
   assign ndar_bad = wbs_we_i && reg_sel && (idx == REG_NDAR) && enable_q;

   // Table fields 0 and 1 only
   assign tbl_we_o    = wr && !reg_sel && !wbs_adr_i[3];
   assign tbl_slot_o  = wbs_adr_i[5:4];
   assign tbl_field_o = wbs_adr_i[2];
   assign tbl_wdata_o = wbs_dat_i;

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         wbs_ack_o <= 1'b0;
         wbs_err_o <= 1'b0;
      end else begin
         wbs_ack_o <= req && !ndar_bad;
         wbs_err_o <= req && ndar_bad;
      end
   end

   // ************************************************************************
   // CCR and NDAR
   // ************************************************************************

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         enable_q     <= 1'b0;
         ndar_dirty_q <= 1'b0;
         int_clear_q  <= 1'b0;
         ndar_slot_q  <= '0;
      end else begin
         int_clear_q <= ccr_wr && wdata.ccr.int_clear;
         if (ccr_wr) begin
            enable_q <= wdata.ccr.enable;
         end
         // A fresh NDAR wins over the FSM's clear
         if (ndar_wr) begin
            ndar_slot_q  <= wdata.ndar.slot;
            ndar_dirty_q <= 1'b1;
         end else if (ctrl_stat_i.ndar_clear) begin
            ndar_dirty_q <= 1'b0;
         end
      end
   end

   assign reg_ctl_o.enable     = enable_q;
   assign reg_ctl_o.ndar_dirty = ndar_dirty_q;
   assign reg_ctl_o.ndar_slot  = ndar_slot_q;
   assign reg_ctl_o.int_clear  = int_clear_q;

   // ************************************************************************
   // Read mux
   // ************************************************************************

   always_comb begin
      ccr_rd        = '0;
      ccr_rd.enable = enable_q;
      ndar_rd       = '0;
      ndar_rd.slot  = ndar_slot_q;
      dar_rd        = '0;
      dar_rd.slot   = ctrl_stat_i.cur_slot;
      rd_mux        = '0;
      if (reg_sel) begin
         case (idx)
            REG_CCR:   rd_mux = ccr_rd;
            REG_CSR:   rd_mux = {30'b0, ctrl_stat_i.busy, ctrl_stat_i.int_pend};
            REG_DAR:   rd_mux = dar_rd;
            REG_NDAR:  rd_mux = ndar_rd;
            REG_COUNT: rd_mux = {16'b0, count_i};
            default:   rd_mux = '0;
         endcase
      end else begin
         case (wbs_adr_i[3:2])
            2'd0:    rd_mux = {tbl_rdata_i.last, 13'b0, tbl_rdata_i.next, tbl_rdata_i.length};
            2'd1:    rd_mux = {tbl_rdata_i.addr, 2'b00};
            default: rd_mux = '0;
         endcase
      end
   end

   // Read data is held for the response cycle
   always_ff @(posedge wb_clk_i) begin
      if (req) begin
         wbs_dat_o <= rd_mux;
      end
   end

   a_resp_excl: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      !(wbs_ack_o && wbs_err_o));

endmodule

// File: design/dma_top.sv
/* Scatter-gather DMA engine, register and control side
   Wishbone register block, descriptor table, chain FSM and beat counter
*/
module dma_top #(
   parameter int DESC_SLOTS = 4
) (
   input  logic        wb_clk_i,
   input  logic        wb_rst_i,
   input  logic        wbs_cyc_i,
   input  logic        wbs_stb_i,
   input  logic        wbs_we_i,
   input  logic [3:0]  wbs_sel_i,
   input  logic [31:0] wbs_adr_i,
   input  logic [31:0] wbs_dat_i,
   output logic [31:0] wbs_dat_o,
   output logic        wbs_ack_o,
   output logic        wbs_err_o,
   output logic        xfer_stb_o,
   output logic [31:0] xfer_adr_o,
   output logic        int_o
);
   import dma_reg_pkg::*;
   import dma_desc_pkg::*;

   reg_ctl_t    reg_ctl;
   ctrl_stat_t  ctrl_stat;
   logic        tbl_we;
   slot_t       tbl_slot;
   logic        tbl_field;
   logic [31:0] tbl_wdata;
   desc_t       bus_desc;
   slot_t       fsm_slot;
   desc_t       fsm_desc;
   logic        load;
   desc_t       load_desc;
   logic        done;
   logic [15:0] count;

   dma_regs dma_regs_i (
      .wb_clk_i    (wb_clk_i),
      .wb_rst_i    (wb_rst_i),
      .wbs_cyc_i   (wbs_cyc_i),
      .wbs_stb_i   (wbs_stb_i),
      .wbs_we_i    (wbs_we_i),
      .wbs_sel_i   (wbs_sel_i),
      .wbs_adr_i   (wbs_adr_i),
      .wbs_dat_i   (wbs_dat_i),
      .wbs_dat_o   (wbs_dat_o),
      .wbs_ack_o   (wbs_ack_o),
      .wbs_err_o   (wbs_err_o),
      .reg_ctl_o   (reg_ctl),
      .tbl_we_o    (tbl_we),
      .tbl_slot_o  (tbl_slot),
      .tbl_field_o (tbl_field),
      .tbl_wdata_o (tbl_wdata),
      .tbl_rdata_i (bus_desc),
      .ctrl_stat_i (ctrl_stat),
      .count_i     (count)
   );

   // Bus reads and writes share the decoded slot
   dma_desc_table #(
      .DESC_SLOTS (DESC_SLOTS)
   ) dma_desc_table_i (
      .wb_clk_i   (wb_clk_i),
      .we_i       (tbl_we),
      .wslot_i    (tbl_slot),
      .wfield_i   (tbl_field),
      .wdata_i    (tbl_wdata),
      .bus_slot_i (tbl_slot),
      .fsm_slot_i (fsm_slot),
      .bus_desc_o (bus_desc),
      .fsm_desc_o (fsm_desc)
   );

   dma_ctrl_fsm dma_ctrl_fsm_i (
      .wb_clk_i    (wb_clk_i),
      .wb_rst_i    (wb_rst_i),
      .reg_ctl_i   (reg_ctl),
      .ctrl_stat_o (ctrl_stat),
      .desc_slot_o (fsm_slot),
      .desc_i      (fsm_desc),
      .load_o      (load),
      .load_desc_o (load_desc),
      .done_i      (done),
      .int_o       (int_o)
   );

   dma_xfer_counter dma_xfer_counter_i (
      .wb_clk_i   (wb_clk_i),
      .wb_rst_i   (wb_rst_i),
      .load_i     (load),
      .desc_i     (load_desc),
      .xfer_stb_o (xfer_stb_o),
      .xfer_adr_o (xfer_adr_o),
      .done_o     (done),
      .count_o    (count)
   );

endmodule

// File: design/dma_xfer_counter.sv
/* Transfer counter
   One address beat per cycle for the loaded descriptor
*/
module dma_xfer_counter (
   input  logic                wb_clk_i,
   input  logic                wb_rst_i,
   input  logic                load_i,
   input  dma_desc_pkg::desc_t desc_i,
   output logic                xfer_stb_o,
   output logic [31:0]         xfer_adr_o,
   output logic                done_o,
   output logic [15:0]         count_o
);
   logic        active_q;
   logic [15:0] cnt_q;
   logic [29:0] adr_q;

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         active_q <= 1'b0;
         cnt_q    <= '0;
      end else if (load_i) begin
         active_q <= 1'b1;
         cnt_q    <= desc_i.length;
      end else if (active_q) begin
         cnt_q <= cnt_q - 16'd1;
         if (cnt_q == 16'd1) begin
            active_q <= 1'b0;
         end
      end
   end

   // Word address, steps once per beat
   always_ff @(posedge wb_clk_i) begin
      if (load_i) begin
         adr_q <= desc_i.addr;
      end else if (active_q) begin
         adr_q <= adr_q + 30'd1;
      end
   end

   assign xfer_stb_o = active_q;
   assign xfer_adr_o = {adr_q, 2'b00};
   assign done_o     = active_q && (cnt_q == 16'd1);
   assign count_o    = cnt_q;

   a_len_nonzero: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      load_i |-> (desc_i.length != 16'd0));

   // The FSM never reloads in the middle of a descriptor
   a_no_overlap: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      load_i |-> !active_q);

endmodule

// File: files.f
design/dma_desc_pkg.sv
design/dma_reg_pkg.sv
design/dma_regs.sv
design/dma_desc_table.sv
design/dma_ctrl_fsm.sv
design/dma_xfer_counter.sv
design/dma_top.sv
sim/dma_checker.sv
sim/dma_tb.sv

// File: sim/dma_checker.sv
/* DMA testbench checker
   Watches the DUT ports, compares them with expected values and keeps counts
*/
module dma_checker (
   input  logic        wb_clk_i,
   input  logic        wbs_ack_i,
   input  logic        wbs_err_i,
   input  logic [31:0] wbs_dat_i,
   input  logic        xfer_stb_i,
   input  logic [31:0] xfer_adr_i,
   input  logic        int_i,
   output int          errors_o
);
   timeunit 1ns;
   timeprecision 100ps;

   localparam int RESP_LIMIT = 8;
   localparam int BEAT_SLACK = 20;

   logic [31:0] beat_q [$];
   int          test_num     = 0;
   int          test_errs    = 0;
   int          tests_failed = 0;
   int          checks       = 0;
   int          errors       = 0;

   assign errors_o = errors;

   // Beats are collected mid-cycle, all DUT outputs come from flops
   always @(negedge wb_clk_i) begin
      if (xfer_stb_i) begin
         beat_q.push_back(xfer_adr_i);
      end
   end

   function automatic void note_error();
      test_errs++;
      errors++;
   endfunction

   // ************************************************************************
   // Bus responses
   // ************************************************************************

   task automatic bus_resp(input logic [31:0] adr, input logic exp_err,
                           input logic chk_data, input logic [31:0] exp_data);
      int waited;
      waited = 0;
      @(negedge wb_clk_i);
      while (!wbs_ack_i && !wbs_err_i && waited < RESP_LIMIT) begin
         @(negedge wb_clk_i);
         waited++;
      end
      checks++;
      if (!wbs_ack_i && !wbs_err_i) begin
         $display("No bus response for address %h within %0d cycles", adr, RESP_LIMIT);
         note_error();
      end else if (wbs_err_i !== exp_err) begin
         $display("ERR wbs_err_o at %h: expected %h, got %h", adr, exp_err, wbs_err_i);
         note_error();
      end else if (chk_data && wbs_dat_i !== exp_data) begin
         $display("ERR wbs_dat_o at %h: expected %h, got %h", adr, exp_data, wbs_dat_i);
         note_error();
      end
   endtask

   // ************************************************************************
   // Beats and interrupt
   // ************************************************************************

   task automatic expect_beats(input int count, input logic [31:0] first,
                               input logic exp_int);
      int          waited;
      int          i;
      logic [31:0] got;
      waited = 0;
      @(posedge wb_clk_i);
      while (beat_q.size() < count && waited < count + BEAT_SLACK) begin
         @(posedge wb_clk_i);
         waited++;
      end
      checks++;
      if (beat_q.size() < count) begin
         $display("Missing beats from %h: expected %0d, saw %0d", first, count,
                  beat_q.size());
         note_error();
         beat_q.delete();
      end else begin
         for (i = 0; i < count; i++) begin
            got = beat_q.pop_front();
            if (got !== first + 32'(4 * i)) begin
               $display("ERR xfer_adr_o beat %0d: expected %h, got %h", i,
                        first + 32'(4 * i), got);
               note_error();
            end
         end
      end
      // The interrupt follows the final beat by one edge
      @(negedge wb_clk_i);
      if (int_i !== exp_int) begin
         $display("ERR int_o: expected %h, got %h", exp_int, int_i);
         note_error();
      end
      // No beat may trail the expected ones
      @(posedge wb_clk_i);
      if (beat_q.size() != 0) begin
         $display("Unexpected extra beats after the expected ones: %0d", beat_q.size());
         note_error();
         beat_q.delete();
      end
   endtask

   task automatic end_test();
      test_num++;
      if (test_errs == 0) begin
         $display("Test %0d passed", test_num);
      end else begin
         $display("Test %0d failed with %0d errors", test_num, test_errs);
         tests_failed++;
      end
      test_errs = 0;
   endtask

   task automatic report();
      $display("Tests %0d, failed %0d, checks %0d, errors %0d", test_num, tests_failed,
               checks, errors);
   endtask

endmodule

// File: sim/dma_golden.txt
// Each line is op_a_b_c in hex, op 01 writes data b to address a and c is 1 for err
// op 02 reads address a and expects b, op 03 expects a beats from byte address b
// and int_o equal to c, op 04 ends a test
// After reset
02_00000400_00000000_00000000
02_00000404_00000000_00000000
02_0000040c_00000000_00000000
03_00000000_00000000_00000000
04_00000000_00000000_00000000
// Descriptor table, both fields of all slots
01_00000000_80010007_00000000
01_00000004_12345678_00000000
01_00000010_00020011_00000000
01_00000014_0000abc0_00000000
01_00000020_80030100_00000000
01_00000024_fffffffc_00000000
01_00000030_0000ffff_00000000
01_00000034_00000004_00000000
02_00000000_80010007_00000000
02_00000004_12345678_00000000
02_00000010_00020011_00000000
02_00000014_0000abc0_00000000
02_00000020_80030100_00000000
02_00000024_fffffffc_00000000
02_00000030_0000ffff_00000000
02_00000034_00000004_00000000
04_00000000_00000000_00000000
// Single descriptor in slot 1, five beats
01_00000014_00001000_00000000
01_00000010_80000005_00000000
01_0000040c_00000010_00000000
01_00000400_00000002_00000000
03_00000005_00001000_00000001
02_00000404_00000001_00000000
04_00000000_00000000_00000000
// NDAR write while enabled
01_0000040c_00000020_00000001
02_0000040c_00000010_00000000
04_00000000_00000000_00000000
// Interrupt clear keeps enable
01_00000400_00000006_00000000
02_00000404_00000000_00000000
02_00000400_00000002_00000000
03_00000000_00000000_00000000
04_00000000_00000000_00000000
// Chain from slot 2 to slot 0
01_00000400_00000000_00000000
01_00000020_00000003_00000000
01_00000024_00002000_00000000
01_00000000_80000004_00000000
01_00000004_00003000_00000000
01_0000040c_00000020_00000000
01_00000400_00000002_00000000
03_00000003_00002000_00000000
03_00000004_00003000_00000001
02_00000404_00000001_00000000
02_00000408_00000000_00000000
02_00000410_00000000_00000000
04_00000000_00000000_00000000

// File: sim/dma_tb.sv
/* DMA engine testbench
   Replays the golden operation list on the Wishbone slave, stops on a timeout
*/
module dma_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int GOLDEN_MAX = 128;
   localparam int OP_CYCLES  = 20;
   localparam int RST_CYCLES = 4;

   // Operation codes in the top byte of each golden word
   localparam logic [7:0] OP_WRITE = 8'h01;
   localparam logic [7:0] OP_READ  = 8'h02;
   localparam logic [7:0] OP_BEATS = 8'h03;
   localparam logic [7:0] OP_END   = 8'h04;

   logic         wb_clk_i;
   logic         wb_rst_i;
   logic         wbs_cyc_i;
   logic         wbs_stb_i;
   logic         wbs_we_i;
   logic [3:0]   wbs_sel_i;
   logic [31:0]  wbs_adr_i;
   logic [31:0]  wbs_dat_i;
   logic [31:0]  wbs_dat_o;
   logic         wbs_ack_o;
   logic         wbs_err_o;
   logic         xfer_stb_o;
   logic [31:0]  xfer_adr_o;
   logic         int_o;
   int           chk_errors;
   logic [103:0] golden [GOLDEN_MAX];
   int           op_count    = 0;
   int           bad_ops     = 0;
   int           cycle_limit = 0;
   int           cycles      = 0;

   dma_top #(
      .DESC_SLOTS (4)
   ) dma_top_i (
      .wb_clk_i   (wb_clk_i),
      .wb_rst_i   (wb_rst_i),
      .wbs_cyc_i  (wbs_cyc_i),
      .wbs_stb_i  (wbs_stb_i),
      .wbs_we_i   (wbs_we_i),
      .wbs_sel_i  (wbs_sel_i),
      .wbs_adr_i  (wbs_adr_i),
      .wbs_dat_i  (wbs_dat_i),
      .wbs_dat_o  (wbs_dat_o),
      .wbs_ack_o  (wbs_ack_o),
      .wbs_err_o  (wbs_err_o),
      .xfer_stb_o (xfer_stb_o),
      .xfer_adr_o (xfer_adr_o),
      .int_o      (int_o)
   );

   dma_checker dma_checker_i (
      .wb_clk_i   (wb_clk_i),
      .wbs_ack_i  (wbs_ack_o),
      .wbs_err_i  (wbs_err_o),
      .wbs_dat_i  (wbs_dat_o),
      .xfer_stb_i (xfer_stb_o),
      .xfer_adr_i (xfer_adr_o),
      .int_i      (int_o),
      .errors_o   (chk_errors)
   );

   always #50 wb_clk_i = ~wb_clk_i;

   // ************************************************************************
   // Timeout
   // ************************************************************************

   always @(posedge wb_clk_i) begin
      cycles <= cycles + 1;
      if (cycle_limit > 0 && cycles >= cycle_limit) begin
         $display("Timeout: the run was stopped after %0d cycles", cycles);
         $display("Verification failed");
         $finish;
      end
   end

   // Limit is the reset, every beat and a fixed allowance per bus operation
   task automatic load_golden();
      logic [7:0] op;
      int         beats;
      int         bus_ops;
      int         i;
      beats   = 0;
      bus_ops = 0;
      for (i = 0; i < GOLDEN_MAX; i++) begin
         golden[i] = '0;
      end
      $readmemh("sim/dma_golden.txt", golden);
      while (op_count < GOLDEN_MAX && golden[op_count][103:96] != 8'h00) begin
         op = golden[op_count][103:96];
         if (op == OP_WRITE || op == OP_READ) begin
            bus_ops++;
         end
         if (op == OP_BEATS) begin
            beats += golden[op_count][95:64];
         end
         op_count++;
      end
      cycle_limit = RST_CYCLES + beats + OP_CYCLES * bus_ops;
   endtask

   // One Wishbone cycle, driven on the falling edge
   task automatic bus_op(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                         input logic exp_err, input logic chk_data,
                         input logic [31:0] exp_data);
      @(negedge wb_clk_i);
      wbs_cyc_i = 1'b1;
      wbs_stb_i = 1'b1;
      wbs_we_i  = we;
      wbs_adr_i = adr;
      wbs_dat_i = dat;
      dma_checker_i.bus_resp(adr, exp_err, chk_data, exp_data);
      wbs_cyc_i = 1'b0;
      wbs_stb_i = 1'b0;
      wbs_we_i  = 1'b0;
   endtask

   task automatic run_op(input logic [103:0] word);
      logic [7:0]  op;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] c;
      op = word[103:96];
      a  = word[95:64];
      b  = word[63:32];
      c  = word[31:0];
      case (op)
         OP_WRITE: bus_op(1'b1, a, b, c[0], 1'b0, 32'h0);
         OP_READ:  bus_op(1'b0, a, 32'h0, 1'b0, 1'b1, b);
         OP_BEATS: dma_checker_i.expect_beats(int'(a), b, c[0]);
         OP_END:   dma_checker_i.end_test();
         default: begin
            $display("Unknown golden operation code %h", op);
            bad_ops++;
         end
      endcase
   endtask

   initial begin
      int i;
      wb_clk_i  = 1'b0;
      wb_rst_i  = 1'b1;
      wbs_cyc_i = 1'b0;
      wbs_stb_i = 1'b0;
      wbs_we_i  = 1'b0;
      wbs_sel_i = 4'hf;
      wbs_adr_i = '0;
      wbs_dat_i = '0;
      load_golden();
      if (op_count == 0) begin
         $display("No operations could be read from the golden file");
         bad_ops++;
      end
      repeat (RST_CYCLES) @(posedge wb_clk_i);
      @(negedge wb_clk_i);
      wb_rst_i = 1'b0;
      for (i = 0; i < op_count; i++) begin
         run_op(golden[i]);
      end
      dma_checker_i.report();
      if (chk_errors == 0 && bad_ops == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule
